//--- stream_pkg.sv
// ####################
// shared widths, constants and struct types of the streaming memory subsystem
// import with stream_pkg::* inside a module body
// ####################
package stream_pkg;

  localparam int unsigned ADDR_W      = 12;    // byte address
  localparam int unsigned WORD_W      = 32;
  localparam int unsigned MEM_WORDS   = 1024;
  localparam int unsigned MEM_AW      = $clog2(MEM_WORDS);  // word address
  localparam int unsigned MEM_LAT     = 1;     // read latency in cycles, 2 works too
  localparam int unsigned OUT_CREDITS = 4;
  localparam int unsigned CRED_W      = $clog2(OUT_CREDITS + 1);
  localparam int unsigned SINK_DEPTH  = 4;     // also the producer's initial credits
  localparam int unsigned CNT_W       = 8;

  typedef struct packed {
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] stride;
    logic [CNT_W-1:0]  count;
  } job_t;

  typedef struct packed {
    logic              req;
    logic              we;
    logic [MEM_AW-1:0] addr;
    logic [WORD_W-1:0] wdata;
  } mem_req_t;

  // lower word from addr, upper word from addr+1
  typedef struct packed {
    logic                rvalid;
    logic [2*WORD_W-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic              valid;
    logic [WORD_W-1:0] data;
  } stream_beat_t;

  typedef logic [1:0] offset_t;

  typedef enum logic [1:0] {IDLE, WORKING, DRAIN} streamer_state_t;

endpackage

//--- credit_fifo.sv
// ####################
// small circular FIFO, payload type set by parameter
// the caller's credits keep it from overflowing
// ####################
`timescale 1ns/1ps

module credit_fifo #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 4
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  T     data_i,
  input  logic pop_i,
  output T     data_o,
  output logic empty_o
);

  localparam int unsigned PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned FILL_W = $clog2(DEPTH + 1);

  T                  mem_q [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q, rd_ptr_q;
  logic [FILL_W-1:0] fill_q;

  assign data_o  = mem_q[rd_ptr_q];   // head is visible without a pop
  assign empty_o = (fill_q == '0);

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      fill_q <= fill_q + FILL_W'(push_i) - FILL_W'(pop_i);
    end
  end

endmodule

//--- addr_gen.sv
// ####################
// linear byte address generator, base + n*stride for count addresses
// ####################
`timescale 1ns/1ps

module addr_gen (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      load_i,
  input  stream_pkg::job_t          job_i,
  input  logic                      step_i,
  output logic [stream_pkg::ADDR_W-1:0] addr_o,
  output logic                      last_o
);

  import stream_pkg::*;

  logic [ADDR_W-1:0] addr_q;
  logic [ADDR_W-1:0] stride_q;
  logic [CNT_W-1:0]  remain_q;   // addresses left, current one included

  assign addr_o = addr_q;
  assign last_o = (remain_q == CNT_W'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q   <= '0;
      stride_q <= '0;
      remain_q <= '0;
    end else if (load_i) begin
      addr_q   <= job_i.base;
      stride_q <= job_i.stride;
      remain_q <= job_i.count;
    end else if (step_i) begin
      addr_q   <= addr_q + stride_q;   // wraps at the top of the byte space
      remain_q <= remain_q - 1'b1;
    end
  end

endmodule

//--- stream_source.sv
// ####################
// read streamer, issues word reads under output credits and realigns
// the two-word response so each beat starts at the requested byte
// ####################
`timescale 1ns/1ps

module stream_source (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     start_i,
  input  stream_pkg::job_t         job_i,
  output logic                     busy_o,
  output logic                     done_o,
  output stream_pkg::mem_req_t     req_o,
  input  logic                     gnt_i,
  input  stream_pkg::mem_rsp_t     rsp_i,
  output stream_pkg::stream_beat_t out_o,
  input  logic                     credit_i
);

  import stream_pkg::*;

  streamer_state_t   cs_q, ns;
  logic [CRED_W-1:0] credit_q;
  logic [CNT_W-1:0]  beat_cnt_q;
  logic [CNT_W-1:0]  job_cnt_q;     // count of the running job
  logic [ADDR_W-1:0] gen_addr;
  logic              gen_last;
  logic              gen_load;
  logic              rd_gnt;
  offset_t           off_head;
  logic              off_empty;

  addr_gen addr_gen_inst (
    .clk_i  ( clk_i    ),
    .rst_ni ( rst_ni   ),
    .load_i ( gen_load ),
    .job_i  ( job_i    ),
    .step_i ( rd_gnt   ),
    .addr_o ( gen_addr ),
    .last_o ( gen_last )
  );

  // byte offsets of reads in flight, popped as data returns
  credit_fifo #(
    .T     ( offset_t    ),
    .DEPTH ( OUT_CREDITS )
  ) off_fifo_inst (
    .clk_i   ( clk_i          ),
    .rst_ni  ( rst_ni         ),
    .push_i  ( rd_gnt         ),
    .data_i  ( gen_addr[1:0]  ),
    .pop_i   ( rsp_i.rvalid   ),
    .data_o  ( off_head       ),
    .empty_o ( off_empty      )
  );

  assign req_o.req   = (cs_q == WORKING) && (credit_q != '0);  // no read without a credit
  assign req_o.we    = 1'b0;
  assign req_o.addr  = gen_addr[ADDR_W-1:2];
  assign req_o.wdata = '0;
  assign rd_gnt      = req_o.req & gnt_i;

  assign out_o.valid = rsp_i.rvalid;
  always_comb begin
    case (off_head)
      2'd0:    out_o.data = rsp_i.rdata[31:0];
      2'd1:    out_o.data = rsp_i.rdata[39:8];
      2'd2:    out_o.data = rsp_i.rdata[47:16];
      default: out_o.data = rsp_i.rdata[55:24];
    endcase
  end

  always_comb begin
    ns       = cs_q;
    gen_load = 1'b0;
    done_o   = 1'b0;
    case (cs_q)
      IDLE: begin
        if (start_i) begin
          ns       = WORKING;
          gen_load = 1'b1;
        end
      end
      WORKING: if (rd_gnt && gen_last) ns = DRAIN;
      default: begin
        // all beats out and nothing left in flight
        if ((beat_cnt_q == job_cnt_q) && off_empty) begin
          ns     = IDLE;
          done_o = 1'b1;
        end
      end
    endcase
  end

  assign busy_o = (cs_q != IDLE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs_q       <= IDLE;
      credit_q   <= CRED_W'(OUT_CREDITS);
      beat_cnt_q <= '0;
      job_cnt_q  <= '0;
    end else begin
      cs_q     <= ns;
      credit_q <= credit_q + CRED_W'(credit_i) - CRED_W'(rd_gnt);
      if (gen_load) begin
        beat_cnt_q <= '0;
        job_cnt_q  <= job_i.count;
      end else if (rsp_i.rvalid) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

endmodule

//--- stream_sink.sv
// ####################
// write streamer, buffers credited input words and writes them to
// word-aligned generated addresses, one credit back per write
// ####################
`timescale 1ns/1ps

module stream_sink (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     start_i,
  input  stream_pkg::job_t         job_i,
  output logic                     busy_o,
  output logic                     done_o,
  input  stream_pkg::stream_beat_t in_i,
  output logic                     credit_o,
  output stream_pkg::mem_req_t     req_o,
  input  logic                     gnt_i
);

  import stream_pkg::*;

  streamer_state_t   cs_q, ns;
  logic [ADDR_W-1:0] gen_addr;
  logic              gen_last;
  logic              wr_gnt;
  logic [WORD_W-1:0] head_word;
  logic              buf_empty;

  addr_gen addr_gen_inst (
    .clk_i  ( clk_i                    ),
    .rst_ni ( rst_ni                   ),
    .load_i ( (cs_q == IDLE) & start_i ),
    .job_i  ( job_i                    ),
    .step_i ( wr_gnt                   ),
    .addr_o ( gen_addr                 ),
    .last_o ( gen_last                 )
  );

  credit_fifo #(
    .T     ( logic [WORD_W-1:0] ),
    .DEPTH ( SINK_DEPTH         )
  ) word_fifo_inst (
    .clk_i   ( clk_i      ),
    .rst_ni  ( rst_ni     ),
    .push_i  ( in_i.valid ),   // producer credits guarantee room
    .data_i  ( in_i.data  ),
    .pop_i   ( wr_gnt     ),
    .data_o  ( head_word  ),
    .empty_o ( buf_empty  )
  );

  assign req_o.req   = (cs_q == WORKING) && !buf_empty;
  assign req_o.we    = 1'b1;
  assign req_o.addr  = gen_addr[ADDR_W-1:2];   // low bits dropped, always aligned
  assign req_o.wdata = head_word;
  assign wr_gnt      = req_o.req & gnt_i;
  assign credit_o    = wr_gnt;

  always_comb begin
    ns = cs_q;
    case (cs_q)
      IDLE:    if (start_i) ns = WORKING;
      WORKING: if (wr_gnt && gen_last) ns = DRAIN;
      default: ns = IDLE;
    endcase
  end

  assign done_o = (cs_q == DRAIN);   // one cycle after the last write
  assign busy_o = (cs_q != IDLE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs_q <= IDLE;
    end else begin
      cs_q <= ns;
    end
  end

endmodule

//--- mem_arbiter.sv
// ####################
// round-robin arbiter between source and sink for the single memory port
// ####################
`timescale 1ns/1ps

module mem_arbiter (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  stream_pkg::mem_req_t src_req_i,
  input  stream_pkg::mem_req_t snk_req_i,
  output logic                 src_gnt_o,
  output logic                 snk_gnt_o,
  output stream_pkg::mem_req_t mem_req_o
);

  logic last_snk_q;   // sink won the last contested or single grant
  logic any_gnt;

  // on contention the peer that did not win last time goes first
  assign src_gnt_o = src_req_i.req & (~snk_req_i.req | last_snk_q);
  assign snk_gnt_o = snk_req_i.req & (~src_req_i.req | ~last_snk_q);
  assign any_gnt   = src_gnt_o | snk_gnt_o;

  always_comb begin
    mem_req_o = '0;
    if (snk_gnt_o) begin
      mem_req_o = snk_req_i;
    end else if (src_gnt_o) begin
      mem_req_o = src_req_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_snk_q <= 1'b1;   // source first after reset
    end else if (any_gnt) begin
      last_snk_q <= snk_gnt_o;
    end
  end

endmodule

//--- scratch_mem.sv
// ####################
// scratchpad word memory, reads return addr and addr+1 after MEM_LAT cycles
// ####################
`timescale 1ns/1ps

module scratch_mem (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  stream_pkg::mem_req_t req_i,
  output stream_pkg::mem_rsp_t rsp_o
);

  import stream_pkg::*;

  logic [WORD_W-1:0]   mem_q [MEM_WORDS];
  logic [2*WORD_W-1:0] rdata_q [MEM_LAT];   // read data delay line
  logic [MEM_LAT-1:0]  rvalid_q;
  logic [MEM_AW-1:0]   next_addr;
  logic                rd_en;

  assign next_addr = req_i.addr + 1'b1;   // wraps to word 0
  assign rd_en     = req_i.req & ~req_i.we;

  always_ff @(posedge clk_i) begin
    if (req_i.req && req_i.we) begin
      mem_q[req_i.addr] <= req_i.wdata;
    end
    if (rd_en) begin
      rdata_q[0] <= {mem_q[next_addr], mem_q[req_i.addr]};
    end
    for (int i = 1; i < MEM_LAT; i++) begin
      rdata_q[i] <= rdata_q[i-1];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= '0;
    end else begin
      rvalid_q[0] <= rd_en;
      for (int i = 1; i < MEM_LAT; i++) begin
        rvalid_q[i] <= rvalid_q[i-1];
      end
    end
  end

  assign rsp_o.rvalid = rvalid_q[MEM_LAT-1];
  assign rsp_o.rdata  = rdata_q[MEM_LAT-1];

endmodule

//--- streamer_top.sv
// ####################
// source and sink streamers sharing one scratchpad through an arbiter
// ####################
`timescale 1ns/1ps

module streamer_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     src_start_i,
  input  stream_pkg::job_t         src_job_i,
  output logic                     src_busy_o,
  output logic                     src_done_o,
  output stream_pkg::stream_beat_t src_out_o,
  input  logic                     src_credit_i,
  input  logic                     snk_start_i,
  input  stream_pkg::job_t         snk_job_i,
  output logic                     snk_busy_o,
  output logic                     snk_done_o,
  input  stream_pkg::stream_beat_t snk_in_i,
  output logic                     snk_credit_o
);

  import stream_pkg::*;

  mem_req_t src_req, snk_req, mem_req;
  mem_rsp_t mem_rsp;        // only the source reads
  logic     src_gnt, snk_gnt;

  stream_source stream_source_inst (
    .clk_i    ( clk_i        ),
    .rst_ni   ( rst_ni       ),
    .start_i  ( src_start_i  ),
    .job_i    ( src_job_i    ),
    .busy_o   ( src_busy_o   ),
    .done_o   ( src_done_o   ),
    .req_o    ( src_req      ),
    .gnt_i    ( src_gnt      ),
    .rsp_i    ( mem_rsp      ),
    .out_o    ( src_out_o    ),
    .credit_i ( src_credit_i )
  );

  stream_sink stream_sink_inst (
    .clk_i    ( clk_i        ),
    .rst_ni   ( rst_ni       ),
    .start_i  ( snk_start_i  ),
    .job_i    ( snk_job_i    ),
    .busy_o   ( snk_busy_o   ),
    .done_o   ( snk_done_o   ),
    .in_i     ( snk_in_i     ),
    .credit_o ( snk_credit_o ),
    .req_o    ( snk_req      ),
    .gnt_i    ( snk_gnt      )
  );

  mem_arbiter mem_arbiter_inst (
    .clk_i     ( clk_i   ),
    .rst_ni    ( rst_ni  ),
    .src_req_i ( src_req ),
    .snk_req_i ( snk_req ),
    .src_gnt_o ( src_gnt ),
    .snk_gnt_o ( snk_gnt ),
    .mem_req_o ( mem_req )
  );

  scratch_mem scratch_mem_inst (
    .clk_i  ( clk_i   ),
    .rst_ni ( rst_ni  ),
    .req_i  ( mem_req ),
    .rsp_o  ( mem_rsp )
  );

endmodule

//--- tb_streamer_top.sv
// ####################
// self-checking testbench for streamer_top that runs a job table through both
// streamers and checks the source beats against a byte-level reference
// ####################
`timescale 1ns/1ps

module tb_streamer_top;

  import stream_pkg::*;

  typedef struct packed {
    logic        run_snk;
    logic        run_src;
    logic        slow;       // long credit delays on the source output
    job_t        snk_job;
    job_t        src_job;
    logic [31:0] seed;       // mixed into the sink data words
  } entry_t;

  logic         clk_i, rst_ni;
  logic         src_start_i, snk_start_i, src_credit_i;
  job_t         src_job_i, snk_job_i;
  logic         src_busy_o, src_done_o, snk_busy_o, snk_done_o, snk_credit_o;
  stream_beat_t src_out_o, snk_in_i;

  entry_t      job_tab[$];
  logic [7:0]  ref_mem [1 << ADDR_W];   // mirrors the scratchpad bytes
  logic [31:0] exp_q[$];                // expected source beats
  logic [31:0] snk_words[$];            // words not yet sent to the sink
  int          delay_q[$];              // wait before each credit goes back
  int          owed, prod_credits;
  int          src_beats_total, src_creds_total;
  int          src_beats_job, src_done_cnt, src_job_cnt;
  int          snk_cred_job, snk_done_cnt;
  int          cycles, limit;
  logic        prev_valid;

  streamer_top streamer_top_inst (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .src_start_i  ( src_start_i  ),
    .src_job_i    ( src_job_i    ),
    .src_busy_o   ( src_busy_o   ),
    .src_done_o   ( src_done_o   ),
    .src_out_o    ( src_out_o    ),
    .src_credit_i ( src_credit_i ),
    .snk_start_i  ( snk_start_i  ),
    .snk_job_i    ( snk_job_i    ),
    .snk_busy_o   ( snk_busy_o   ),
    .snk_done_o   ( snk_done_o   ),
    .snk_in_i     ( snk_in_i     ),
    .snk_credit_o ( snk_credit_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic report_failure(input string what);
    $display("error at %0t ns: %s", $time, what);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  function automatic job_t make_job(input int base, input int stride, input int count);
    job_t j;
    j.base   = ADDR_W'(base);
    j.stride = ADDR_W'(stride);
    j.count  = CNT_W'(count);
    return j;
  endfunction

  task automatic add_entry(input logic snk, input logic src, input logic slow,
                           input job_t snk_job, input job_t src_job, input logic [31:0] seed);
    entry_t e;
    e.run_snk = snk;
    e.run_src = src;
    e.slow    = slow;
    e.snk_job = snk_job;
    e.src_job = src_job;
    e.seed    = seed;
    job_tab.push_back(e);
  endtask

  // little endian with the byte at addr in bits 7:0
  function automatic logic [31:0] read_ref(input int addr);
    logic [31:0] w;
    for (int k = 0; k < 4; k++) begin
      w[8*k +: 8] = ref_mem[(addr + k) % (1 << ADDR_W)];
    end
    return w;
  endfunction

  task automatic setup_entry(input entry_t e);
    int          a;
    logic [31:0] w;
    src_beats_job = 0;
    src_done_cnt  = 0;
    snk_cred_job  = 0;
    snk_done_cnt  = 0;
    src_job_cnt   = e.run_src ? e.src_job.count : 0;
    for (int i = 0; i < src_job_cnt; i++) begin
      a = (e.src_job.base + i * e.src_job.stride) % (1 << ADDR_W);
      exp_q.push_back(read_ref(a));
      delay_q.push_back(e.slow ? $urandom % 40 : $urandom % 4);
    end
    for (int i = 0; e.run_snk && i < e.snk_job.count; i++) begin
      a = ((e.snk_job.base + i * e.snk_job.stride) % (1 << ADDR_W)) & ~3;  // sink aligns
      w = $urandom ^ e.seed;
      snk_words.push_back(w);
      for (int k = 0; k < 4; k++) begin
        ref_mem[a + k] = w[8*k +: 8];
      end
    end
  endtask

  task automatic run_entry(input entry_t e);
    @(negedge clk_i);
    setup_entry(e);
    @(posedge clk_i);
    if (e.run_src) begin
      src_job_i   <= e.src_job;
      src_start_i <= 1'b1;
    end
    if (e.run_snk) begin
      snk_job_i   <= e.snk_job;
      snk_start_i <= 1'b1;
    end
    @(posedge clk_i);
    src_start_i <= 1'b0;
    snk_start_i <= 1'b0;
    do @(negedge clk_i);
    while ((e.run_src && src_done_cnt == 0) || (e.run_snk && snk_done_cnt == 0));
    repeat (4) @(negedge clk_i);   // room for a stray second done
    while (owed > 0) @(negedge clk_i);
    if (e.run_src) begin
      check_equal(src_done_cnt, 1, "source done pulses per job");
      check_equal(exp_q.size(), 0, "source beats still missing");
    end
    if (e.run_snk) begin
      check_equal(snk_done_cnt, 1, "sink done pulses per job");
      check_equal(snk_cred_job, e.snk_job.count, "sink credits per job");
      check_equal(snk_words.size(), 0, "sink words left unsent");
    end
  endtask

  // producer spends sink credits
  initial begin
    stream_beat_t beat;
    snk_in_i = '0;
    forever begin
      @(posedge clk_i);
      if (snk_words.size() > 0 && prod_credits > 0) begin
        beat.valid = 1'b1;
        beat.data  = snk_words.pop_front();
        snk_in_i  <= beat;
        prod_credits--;
      end else begin
        snk_in_i <= '0;
      end
    end
  end

  // consumer hands source credits back after a delay
  initial begin
    int delay;
    src_credit_i = 1'b0;
    forever begin
      @(posedge clk_i);
      src_credit_i <= 1'b0;
      if (owed > 0) begin
        delay = (delay_q.size() > 0) ? delay_q.pop_front() : 0;
        repeat (delay) @(posedge clk_i);
        src_credit_i <= 1'b1;
        owed--;
      end
    end
  end

  // outputs sampled mid-cycle
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (src_credit_i) src_creds_total++;
      if (src_out_o.valid) begin
        if (exp_q.size() == 0) begin
          report_failure("source sent a beat that no job asked for");
        end else begin
          check_equal(src_out_o.data, exp_q.pop_front(), "source beat data");
        end
        src_beats_total++;
        src_beats_job++;
        owed++;
        if (src_beats_total - src_creds_total > OUT_CREDITS) begin
          report_failure("source sent more beats than it held credits for");
        end
      end
      if (src_done_o) begin
        check_equal(src_beats_job, src_job_cnt, "source beats before done");
        check_equal(prev_valid, 1'b1, "source done right after last beat");
        src_done_cnt++;
      end
      prev_valid = src_out_o.valid;
      if (snk_credit_o) begin
        prod_credits++;
        snk_cred_job++;
      end
      if (snk_done_o) snk_done_cnt++;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: the run took more than %0d cycles", limit);
      $display("FAIL: see errors above");
      $fatal(1, "timeout");
    end
  end

  initial begin
    job_t idle_job;
    void'($urandom(32'hdc19_eeb9));
    rst_ni       = 1'b0;
    src_start_i  = 1'b0;
    snk_start_i  = 1'b0;
    src_job_i    = '0;
    snk_job_i    = '0;
    prod_credits = SINK_DEPTH;
    prev_valid   = 1'b0;
    idle_job     = make_job(0, 0, 0);

    add_entry(1, 0, 0, make_job(0, 4, 32), idle_job, 32'h5a5a_0001);      // fill bytes 0..127
    add_entry(0, 1, 0, idle_job, make_job(0, 4, 16), 0);                  // aligned read back
    add_entry(0, 1, 0, idle_job, make_job(1, 4, 12), 0);
    add_entry(0, 1, 0, idle_job, make_job(2, 4, 12), 0);
    add_entry(0, 1, 0, idle_job, make_job(3, 4, 12), 0);
    add_entry(0, 1, 0, idle_job, make_job(5, 8, 10), 0);
    add_entry(0, 1, 0, idle_job, make_job(6, 0, 6), 0);                   // same word every beat
    add_entry(0, 1, 1, idle_job, make_job(1, 4, 20), 0);                  // credits held back
    add_entry(1, 1, 0, make_job(512, 4, 16), make_job(16, 4, 16), 32'h3c3c_0002);
    add_entry(0, 1, 0, idle_job, make_job(513, 4, 14), 0);                // reads the concurrent write

    limit = 200;
    foreach (job_tab[n]) begin
      limit += 20 * ((job_tab[n].run_snk ? job_tab[n].snk_job.count : 0) +
                     (job_tab[n].run_src ? job_tab[n].src_job.count : 0));
    end

    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (6) begin
      @(negedge clk_i);
      check_equal({src_out_o.valid, src_done_o, snk_done_o, snk_credit_o, src_busy_o, snk_busy_o},
                  '0, "outputs idle after reset");
    end

    foreach (job_tab[n]) begin
      run_entry(job_tab[n]);
    end

    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- all.f
stream_pkg.sv
credit_fifo.sv
addr_gen.sv
stream_source.sv
stream_sink.sv
mem_arbiter.sv
scratch_mem.sv
streamer_top.sv
tb_streamer_top.sv

//--- Bender.yml
package:
  name: streamer_top

sources:
  - stream_pkg.sv
  - credit_fifo.sv
  - addr_gen.sv
  - stream_source.sv
  - stream_sink.sv
  - mem_arbiter.sv
  - scratch_mem.sv
  - streamer_top.sv
  - target: test
    files:
      - tb_streamer_top.sv
